//--- build.f
+incdir+source
source/lsu_pkg.sv
source/lsu.sv
source/load_align.sv
source/data_ram.sv
source/lsu_mem_top.sv
verif/lsu_asserts.sv
verif/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the simulation log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --assert --top-module lsu_tb -Mdir obj_dir -f build.f > build.log 2>&1 \
  && ./obj_dir/Vlsu_tb > sim.log 2>&1 \
  || cat build.log sim.log 2>/dev/null
grep -q "Result: PASSED" sim.log 2>/dev/null && echo "Simulation passed" && exit 0
echo "Simulation failed, see build.log and sim.log"
exit 1

//--- source/data_ram.sv
/*
 * Data RAM as core bus slave
 * Separate read and write channels, one pending address per channel,
 * byte strobed writes, external stalls and an error region
 */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module data_ram (
  input  logic                   clk,
  input  logic                   reset_i,
  // Back-pressure from outside
  input  logic                   stall_addr_i,
  input  logic                   stall_data_i,
  // Read address and data channels
  input  logic [`LSU_XLEN-1:0]   rd_addr_i,
  input  logic                   rd_addr_valid_i,
  output logic                   rd_addr_ready_o,
  output logic [`LSU_XLEN-1:0]   rd_data_o,
  output lsu_pkg::cb_resp_e      rd_resp_o,
  output logic                   rd_valid_o,
  // Write address, data and response channels
  input  logic [`LSU_XLEN-1:0]   wr_addr_i,
  input  logic                   wr_addr_valid_i,
  output logic                   wr_addr_ready_o,
  input  logic [`LSU_XLEN-1:0]   wr_data_i,
  input  logic [`LSU_XLEN/8-1:0] wr_strobe_i,
  input  logic                   wr_data_valid_i,
  output logic                   wr_data_ready_o,
  output logic                   wr_resp_valid_o,
  output lsu_pkg::cb_resp_e      wr_resp_o
);

  localparam int NB = `LSU_XLEN / 8;

  lsu_pkg::cb_word_u     mem [`LSU_RAM_WORDS];

  logic                  rd_pend_q;
  logic [`LSU_XLEN-1:0]  rd_addr_q;
  logic                  wr_pend_q;
  logic [`LSU_XLEN-1:0]  wr_addr_q;
  logic                  wr_resp_valid_q;
  lsu_pkg::cb_resp_e     wr_resp_q;

  logic                  rd_acc;
  logic                  wr_acc;
  logic                  wd_acc;
  logic                  rd_hit;
  logic                  wr_hit;
  logic [`LSU_RAM_AW-1:0] rd_idx;
  logic [`LSU_RAM_AW-1:0] wr_idx;
  lsu_pkg::cb_word_u     wr_word;

  // Word address inside the RAM
  function automatic logic in_range(input logic [`LSU_XLEN-1:0] addr);
    return addr[`LSU_XLEN-1:2] < (`LSU_XLEN-2)'(`LSU_RAM_WORDS);
  endfunction

  assign rd_addr_ready_o = !stall_addr_i;
  assign wr_addr_ready_o = !stall_addr_i;
  assign wr_data_ready_o = !stall_data_i;

  assign rd_acc = rd_addr_valid_i && rd_addr_ready_o;
  assign wr_acc = wr_addr_valid_i && wr_addr_ready_o;
  assign wd_acc = wr_data_valid_i && wr_data_ready_o && wr_pend_q;

  assign rd_hit  = in_range(rd_addr_q);
  assign wr_hit  = in_range(wr_addr_q);
  assign rd_idx  = rd_addr_q[`LSU_RAM_AW+1:2];
  assign wr_idx  = wr_addr_q[`LSU_RAM_AW+1:2];
  assign wr_word = lsu_pkg::cb_word_u'(wr_data_i);

  // Pending read data is held until the data stall drops
  assign rd_valid_o = rd_pend_q && !stall_data_i;
  assign rd_data_o  = rd_hit ? mem[rd_idx] : '0;
  assign rd_resp_o  = rd_hit ? lsu_pkg::CB_OKAY : lsu_pkg::CB_ERROR;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rd_pend_q       <= 1'b0;
      wr_pend_q       <= 1'b0;
      wr_resp_valid_q <= 1'b0;
    end else begin
      if (rd_acc) begin
        rd_pend_q <= 1'b1;
      end else if (rd_valid_o) begin
        rd_pend_q <= 1'b0;
      end
      if (wr_acc) begin
        wr_pend_q <= 1'b1;
      end else if (wd_acc) begin
        wr_pend_q <= 1'b0;
      end
      wr_resp_valid_q <= wd_acc;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      rd_addr_q <= rd_addr_i;
    end
    if (wr_acc) begin
      wr_addr_q <= wr_addr_i;
    end
    if (wd_acc) begin
      wr_resp_q <= wr_hit ? lsu_pkg::CB_OKAY : lsu_pkg::CB_ERROR;
    end
  end

  // Strobed write, nothing lands in the error region
  always_ff @(posedge clk) begin
    if (wd_acc && wr_hit) begin
      for (int b = 0; b < NB; b++) begin
        if (wr_strobe_i[b]) begin
          mem[wr_idx].bytes[b] <= wr_word.bytes[b];
        end
      end
    end
  end

  assign wr_resp_valid_o = wr_resp_valid_q;
  assign wr_resp_o       = wr_resp_q;

endmodule

//--- source/load_align.sv
/*
 * Load aligner
 * Picks the loaded byte, half or word out of the bus word
 * and sign- or zero-extends it for write-back
 */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module load_align (
  input  logic                  rd_valid_i,
  input  logic [`LSU_XLEN-1:0]  rd_data_i,
  input  lsu_pkg::lsu_op_e      wb_op_i,
  input  lsu_pkg::lsu_width_e   wb_width_i,
  input  logic [1:0]            wb_addr_lo_i,
  output logic                  wb_valid_o,
  output logic [`LSU_XLEN-1:0]  wb_data_o
);

  lsu_pkg::cb_word_u word;
  logic [7:0]        sel_byte;
  logic [15:0]       sel_half;

  assign word     = lsu_pkg::cb_word_u'(rd_data_i);
  assign sel_byte = word.bytes[wb_addr_lo_i];
  // Half select ignores bit 0, a straddling half is truncated
  assign sel_half = word.halves[wb_addr_lo_i[1]];

  always_comb begin
    case (wb_width_i)
      lsu_pkg::LSU_B: begin
        wb_data_o = {{(`LSU_XLEN-8){sel_byte[7]}}, sel_byte};
      end
      lsu_pkg::LSU_BU: begin
        wb_data_o = {{(`LSU_XLEN-8){1'b0}}, sel_byte};
      end
      lsu_pkg::LSU_H: begin
        wb_data_o = {{(`LSU_XLEN-16){sel_half[15]}}, sel_half};
      end
      lsu_pkg::LSU_HU: begin
        wb_data_o = {{(`LSU_XLEN-16){1'b0}}, sel_half};
      end
      default: begin
        wb_data_o = word;
      end
    endcase
  end

  // Read data only retires a load
  assign wb_valid_o = rd_valid_i && (wb_op_i == lsu_pkg::LSU_LOAD);

endmodule

//--- source/lsu.sv
/*
 * Load/store unit
 * Splits each memory operation into an address and a data phase,
 * holds the address stable while the bus stalls, back-pressures
 * the execute stage and raises access-fault pulses
 */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu #(
  parameter int SUPPORT_WR_RESP = `LSU_WR_RESP
) (
  input  logic                  clk,
  input  logic                  reset_i,
  // Execute stage request
  input  lsu_pkg::lsu_op_e      op_i,
  input  lsu_pkg::lsu_width_e   width_i,
  input  logic [`LSU_XLEN-1:0]  addr_i,
  input  logic [`LSU_XLEN-1:0]  wdata_i,
  output logic                  bp_o,
  // Data phase info for write-back
  output lsu_pkg::lsu_op_e      wb_op_o,
  output lsu_pkg::lsu_width_e   wb_width_o,
  output logic [1:0]            wb_addr_lo_o,
  // Core bus read channels
  output logic [`LSU_XLEN-1:0]  rd_addr_o,
  output logic                  rd_addr_valid_o,
  input  logic                  rd_addr_ready_i,
  input  logic                  rd_valid_i,
  input  lsu_pkg::cb_resp_e     rd_resp_i,
  // Core bus write channels
  output logic [`LSU_XLEN-1:0]  wr_addr_o,
  output logic                  wr_addr_valid_o,
  input  logic                  wr_addr_ready_i,
  output logic [`LSU_XLEN-1:0]  wr_data_o,
  output logic [`LSU_XLEN/8-1:0] wr_strobe_o,
  output logic                  wr_data_valid_o,
  input  logic                  wr_data_ready_i,
  input  logic                  wr_resp_valid_i,
  input  lsu_pkg::cb_resp_e     wr_resp_i,
  // Access faults
  output logic                  trap_ld_o,
  output logic                  trap_st_o
);

  localparam int NB = `LSU_XLEN / 8;

  // Data phase copy of the operation
  lsu_pkg::lsu_op_e     dp_op_q;
  lsu_pkg::lsu_width_e  dp_width_q;
  logic [1:0]           dp_addr_lo_q;
  logic [`LSU_XLEN-1:0] dp_wdata_q;
  logic                 dp_done_q;
  logic                 dp_done_d;

  // Address held while the address channel stalls
  logic                 lock_q;
  logic                 lock_d;
  logic [`LSU_XLEN-1:0] locked_addr_q;
  logic [`LSU_XLEN-1:0] req_addr;

  logic                 ap_rd;
  logic                 ap_wr;
  logic                 dp_rd;
  logic                 dp_wr;
  logic                 bp_addr;
  logic                 bp_data;
  logic [`LSU_XLEN-1:0] wdata_shift;

  // Byte lanes touched by a store, before truncation to the word
  function automatic logic [NB-1:0] byte_mask(input lsu_pkg::lsu_width_e width,
                                              input logic [1:0] lo);
    logic [NB-1:0] mask;
    case (width)
      lsu_pkg::LSU_B, lsu_pkg::LSU_BU: mask = NB'(1);
      lsu_pkg::LSU_H, lsu_pkg::LSU_HU: mask = NB'(3);
      default:                         mask = '1;
    endcase
    return mask << lo;
  endfunction

  assign ap_rd = (op_i == lsu_pkg::LSU_LOAD);
  assign ap_wr = (op_i == lsu_pkg::LSU_STORE);
  assign dp_rd = (dp_op_q == lsu_pkg::LSU_LOAD);
  assign dp_wr = (dp_op_q == lsu_pkg::LSU_STORE);

  // Data phase stalls until its transfer, then stays done
  always_comb begin
    bp_data = 1'b0;
    if ((dp_rd || dp_wr) && !dp_done_q) begin
      bp_data = dp_rd ? !rd_valid_i : !wr_data_ready_i;
    end
  end

  // Store data lanes
  assign wr_strobe_o     = byte_mask(dp_width_q, dp_addr_lo_q);
  assign wdata_shift     = dp_wdata_q << {dp_addr_lo_q, 3'b000};
  assign wr_data_valid_o = dp_wr && !dp_done_q;

  always_comb begin
    for (int b = 0; b < NB; b++) begin
      wr_data_o[b*8 +: 8] = wr_strobe_o[b] ? wdata_shift[b*8 +: 8] : 8'h00;
    end
  end

  // Address phase
  // The next address waits for the data phase, whose result may feed it
  assign req_addr        = lock_q ? locked_addr_q : addr_i;
  assign rd_addr_o       = {req_addr[`LSU_XLEN-1:2], 2'b00};
  assign wr_addr_o       = {req_addr[`LSU_XLEN-1:2], 2'b00};
  assign rd_addr_valid_o = ap_rd && !bp_data;
  assign wr_addr_valid_o = ap_wr && !bp_data;

  assign bp_addr = (ap_rd && !rd_addr_ready_i) || (ap_wr && !wr_addr_ready_i);
  assign bp_o    = bp_addr || bp_data;

  // Lock once a raised valid meets a low ready
  assign lock_d    = (rd_addr_valid_o && !rd_addr_ready_i) ||
                     (wr_addr_valid_o && !wr_addr_ready_i);
  // Data phase finished while the next address is still stalled
  assign dp_done_d = bp_o && !bp_data && (dp_rd || dp_wr);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      dp_op_q   <= lsu_pkg::NO_LSU;
      dp_done_q <= 1'b0;
      lock_q    <= 1'b0;
    end else begin
      dp_done_q <= dp_done_d;
      lock_q    <= lock_d;
      if (!bp_o) begin
        dp_op_q <= op_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!lock_q) begin
      locked_addr_q <= addr_i;
    end
    if (!bp_o) begin
      dp_width_q   <= width_i;
      dp_addr_lo_q <= req_addr[1:0];
      dp_wdata_q   <= wdata_i;
    end
  end

  assign wb_op_o      = dp_op_q;
  assign wb_width_o   = dp_width_q;
  assign wb_addr_lo_o = dp_addr_lo_q;

  // Access-fault pulses on an error response
  assign trap_ld_o = rd_valid_i && (rd_resp_i != lsu_pkg::CB_OKAY);
  assign trap_st_o = (SUPPORT_WR_RESP == 1) && wr_resp_valid_i &&
                     (wr_resp_i != lsu_pkg::CB_OKAY);

endmodule

//--- source/lsu_consts.svh
/*
 * Shared constants for the load/store unit and its data RAM
 * Data and address width, RAM depth and index width,
 * and the default for store response checking
 */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data and address width of the core bus
`define LSU_XLEN 32

// Data RAM depth in words
// Word addresses at or above this answer with an error
`define LSU_RAM_WORDS 256

// Index width into the data RAM
`define LSU_RAM_AW 8

// Check write responses for access faults
`define LSU_WR_RESP 1

`endif

//--- source/lsu_mem_top.sv
/*
 * Memory side top level
 * Load/store unit, load aligner and data RAM on the core bus
 */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_mem_top (
  input  logic                  clk,
  input  logic                  reset_i,
  input  lsu_pkg::lsu_op_e      op_i,
  input  lsu_pkg::lsu_width_e   width_i,
  input  logic [`LSU_XLEN-1:0]  addr_i,
  input  logic [`LSU_XLEN-1:0]  wdata_i,
  input  logic                  stall_addr_i,
  input  logic                  stall_data_i,
  output logic                  bp_o,
  output logic                  wb_valid_o,
  output logic [`LSU_XLEN-1:0]  wb_data_o,
  output logic                  trap_ld_o,
  output logic                  trap_st_o
);

  // Write-back info from the data phase
  lsu_pkg::lsu_op_e      wb_op;
  lsu_pkg::lsu_width_e   wb_width;
  logic [1:0]            wb_addr_lo;

  // Core bus
  logic [`LSU_XLEN-1:0]   rd_addr;
  logic                   rd_addr_valid;
  logic                   rd_addr_ready;
  logic [`LSU_XLEN-1:0]   rd_data;
  lsu_pkg::cb_resp_e      rd_resp;
  logic                   rd_valid;
  logic [`LSU_XLEN-1:0]   wr_addr;
  logic                   wr_addr_valid;
  logic                   wr_addr_ready;
  logic [`LSU_XLEN-1:0]   wr_data;
  logic [`LSU_XLEN/8-1:0] wr_strobe;
  logic                   wr_data_valid;
  logic                   wr_data_ready;
  logic                   wr_resp_valid;
  lsu_pkg::cb_resp_e      wr_resp;

  lsu lsu_i (
    .clk, .reset_i, .op_i, .width_i, .addr_i, .wdata_i, .bp_o,
    .wb_op_o(wb_op), .wb_width_o(wb_width), .wb_addr_lo_o(wb_addr_lo),
    .rd_addr_o(rd_addr), .rd_addr_valid_o(rd_addr_valid),
    .rd_addr_ready_i(rd_addr_ready), .rd_valid_i(rd_valid), .rd_resp_i(rd_resp),
    .wr_addr_o(wr_addr), .wr_addr_valid_o(wr_addr_valid),
    .wr_addr_ready_i(wr_addr_ready), .wr_data_o(wr_data), .wr_strobe_o(wr_strobe),
    .wr_data_valid_o(wr_data_valid), .wr_data_ready_i(wr_data_ready),
    .wr_resp_valid_i(wr_resp_valid), .wr_resp_i(wr_resp),
    .trap_ld_o, .trap_st_o
  );

  load_align load_align_i (
    .rd_valid_i(rd_valid), .rd_data_i(rd_data), .wb_op_i(wb_op),
    .wb_width_i(wb_width), .wb_addr_lo_i(wb_addr_lo),
    .wb_valid_o, .wb_data_o
  );

  data_ram data_ram_i (
    .clk, .reset_i, .stall_addr_i, .stall_data_i,
    .rd_addr_i(rd_addr), .rd_addr_valid_i(rd_addr_valid), .rd_addr_ready_o(rd_addr_ready),
    .rd_data_o(rd_data), .rd_resp_o(rd_resp), .rd_valid_o(rd_valid),
    .wr_addr_i(wr_addr), .wr_addr_valid_i(wr_addr_valid), .wr_addr_ready_o(wr_addr_ready),
    .wr_data_i(wr_data), .wr_strobe_i(wr_strobe), .wr_data_valid_i(wr_data_valid),
    .wr_data_ready_o(wr_data_ready), .wr_resp_valid_o(wr_resp_valid), .wr_resp_o(wr_resp)
  );

endmodule

//--- source/lsu_pkg.sv
/*
 * Types shared by the load/store unit, load aligner and data RAM
 * Memory operation, access width and bus response enums,
 * plus the bus data word union with byte and half views
 */
`include "lsu_consts.svh"

package lsu_pkg;

  // Memory operation from the execute stage
  typedef enum logic [1:0] {
    NO_LSU    = 2'b00,
    LSU_LOAD  = 2'b01,
    LSU_STORE = 2'b10
  } lsu_op_e;

  // Access width, encoded like funct3 of loads and stores
  typedef enum logic [2:0] {
    LSU_B  = 3'b000,
    LSU_H  = 3'b001,
    LSU_W  = 3'b010,
    LSU_BU = 3'b100,
    LSU_HU = 3'b101
  } lsu_width_e;

  // Core bus response
  typedef enum logic [1:0] {
    CB_OKAY  = 2'b00,
    CB_ERROR = 2'b10
  } cb_resp_e;

  // One bus word, seen as bytes or as halves
  typedef union packed {
    logic [`LSU_XLEN/8-1:0][7:0]   bytes;
    logic [`LSU_XLEN/16-1:0][15:0] halves;
  } cb_word_u;

endpackage

//--- verif/lsu_asserts.sv
/*
 * Core bus protocol checks for the load/store unit
 * Read address, write address and write data hold until ready
 */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_asserts (
  input logic                   clk,
  input logic                   reset_i,
  input logic [`LSU_XLEN-1:0]   rd_addr_o,
  input logic                   rd_addr_valid_o,
  input logic                   rd_addr_ready_i,
  input logic [`LSU_XLEN-1:0]   wr_addr_o,
  input logic                   wr_addr_valid_o,
  input logic                   wr_addr_ready_i,
  input logic [`LSU_XLEN-1:0]   wr_data_o,
  input logic [`LSU_XLEN/8-1:0] wr_strobe_o,
  input logic                   wr_data_valid_o,
  input logic                   wr_data_ready_i
);

  // A raised valid keeps its payload until the transfer
  rd_addr_hold: assert property (@(posedge clk) disable iff (reset_i)
    rd_addr_valid_o && !rd_addr_ready_i |=> rd_addr_valid_o && $stable(rd_addr_o))
    else $error("read address dropped or changed before it was accepted");

  wr_addr_hold: assert property (@(posedge clk) disable iff (reset_i)
    wr_addr_valid_o && !wr_addr_ready_i |=> wr_addr_valid_o && $stable(wr_addr_o))
    else $error("write address dropped or changed before it was accepted");

  wr_data_hold: assert property (@(posedge clk) disable iff (reset_i)
    wr_data_valid_o && !wr_data_ready_i |=>
      wr_data_valid_o && $stable(wr_data_o) && $stable(wr_strobe_o))
    else $error("write data or strobe dropped or changed before it was accepted");

endmodule

//--- verif/lsu_tb.sv
/*
 * Testbench for the memory side top level
 * Clock, reset, LFSR stimulus with random bus stalls,
 * shadow memory model, output checks and a cycle timeout
 */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_tb;

  localparam int N_FILL     = 64;
  localparam int N_DIRECT   = 26;
  localparam int N_RANDOM   = 400;
  localparam int MAX_CYCLES = 40 * (N_FILL + N_DIRECT + N_RANDOM) + 100;

  logic                 clk;
  logic                 reset_i;
  lsu_pkg::lsu_op_e     op_i;
  lsu_pkg::lsu_width_e  width_i;
  logic [`LSU_XLEN-1:0] addr_i;
  logic [`LSU_XLEN-1:0] wdata_i;
  logic                 stall_addr_i;
  logic                 stall_data_i;
  logic                 bp_o;
  logic                 wb_valid_o;
  logic [`LSU_XLEN-1:0] wb_data_o;
  logic                 trap_ld_o;
  logic                 trap_st_o;

  // Shadow memory and the loads still to retire
  logic [31:0] shadow [`LSU_RAM_WORDS];
  logic [31:0] exp_data_q [$];
  logic        exp_trap_q [$];
  // Cycle the load was presented, -1 when latency is not checked
  int          exp_cyc_q [$];
  int          st_faults_pending;
  logic [31:0] lfsr_state;
  logic        stalls_on;
  int          cyc = 0;
  string       test_name;

  lsu_mem_top lsu_mem_top_i (.*);

  bind lsu lsu_asserts lsu_asserts_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout in %s after %0d cycles, an operation never finished", test_name, cyc);
      $display("Result: FAILED");
      $fatal(1, "Simulation timed out");
    end
  end

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[ERROR] %s: %s expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
    $display("Result: FAILED");
    $fatal(1, "Value mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("Error in %s: %s", test_name, msg);
    $display("Result: FAILED");
    $fatal(1, "Protocol error");
  endtask

  // Galois LFSR, x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic lsu_pkg::lsu_width_e pick_width(input logic [2:0] sel);
    case (sel)
      3'd0:    return lsu_pkg::LSU_B;
      3'd1:    return lsu_pkg::LSU_H;
      3'd3:    return lsu_pkg::LSU_BU;
      3'd4:    return lsu_pkg::LSU_HU;
      default: return lsu_pkg::LSU_W;
    endcase
  endfunction

  // Write-back value of a load from a stored word
  function automatic logic [31:0] expect_load(input logic [31:0] word,
                                              input lsu_pkg::lsu_width_e width,
                                              input logic [1:0] lo);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*lo +: 8];
    h = word[16*lo[1] +: 16];
    case (width)
      lsu_pkg::LSU_B:  return {{24{b[7]}}, b};
      lsu_pkg::LSU_BU: return {24'h0, b};
      lsu_pkg::LSU_H:  return {{16{h[15]}}, h};
      lsu_pkg::LSU_HU: return {16'h0, h};
      default:         return word;
    endcase
  endfunction

  function automatic logic [31:0] merge_store(input logic [31:0] old,
                                              input lsu_pkg::lsu_width_e width,
                                              input logic [1:0] lo,
                                              input logic [31:0] wdata);
    logic [31:0] word;
    word = old;
    case (width)
      lsu_pkg::LSU_B, lsu_pkg::LSU_BU: word[8*lo +: 8] = wdata[7:0];
      lsu_pkg::LSU_H, lsu_pkg::LSU_HU: word[16*lo[1] +: 16] = wdata[15:0];
      default:                         word = wdata;
    endcase
    return word;
  endfunction

  task automatic drive_stalls();
    logic [31:0] r;
    take_bits(4, r);
    // Each stall high about a quarter of the cycles
    stall_addr_i = stalls_on && (r[1:0] == 2'b00);
    stall_data_i = stalls_on && (r[3:2] == 2'b00);
  endtask

  task automatic note_accept(input lsu_pkg::lsu_op_e op, input lsu_pkg::lsu_width_e width,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input int start);
    logic hit;
    hit = addr[31:2] < 30'(`LSU_RAM_WORDS);
    if (op == lsu_pkg::LSU_LOAD) begin
      exp_data_q.push_back(hit ?
        expect_load(shadow[addr[`LSU_RAM_AW+1:2]], width, addr[1:0]) : 32'h0);
      exp_trap_q.push_back(!hit);
      exp_cyc_q.push_back(stalls_on ? -1 : start);
    end else if (op == lsu_pkg::LSU_STORE) begin
      if (hit) begin
        shadow[addr[`LSU_RAM_AW+1:2]] =
          merge_store(shadow[addr[`LSU_RAM_AW+1:2]], width, addr[1:0], wdata);
      end else begin
        st_faults_pending++;
      end
    end
  endtask

  task automatic watch_outputs();
    logic [31:0] exp_data;
    logic        exp_trap;
    int          start;
    if (wb_valid_o) begin
      assert (exp_data_q.size() != 0) else abort_run("wb_valid_o rose with no load outstanding");
      exp_data = exp_data_q.pop_front();
      exp_trap = exp_trap_q.pop_front();
      start    = exp_cyc_q.pop_front();
      assert (wb_data_o === exp_data) else report_mismatch("wb_data_o", exp_data, wb_data_o);
      assert (trap_ld_o === exp_trap)
        else report_mismatch("trap_ld_o", 32'(exp_trap), 32'(trap_ld_o));
      if (start >= 0) begin
        assert (cyc - start == 1)
          else report_mismatch("load latency", 32'd1, 32'(cyc - start));
      end
    end else begin
      assert (!trap_ld_o) else abort_run("trap_ld_o rose without a load returning");
    end
    if (trap_st_o) begin
      assert (st_faults_pending > 0) else abort_run("trap_st_o rose for a store inside the RAM");
      st_faults_pending--;
    end
  endtask

  // Present one operation and hold it until bp_o lets it through
  task automatic run_op(input lsu_pkg::lsu_op_e op, input lsu_pkg::lsu_width_e width,
                        input logic [31:0] addr, input logic [31:0] wdata);
    logic acc;
    int   start;
    op_i    = op;
    width_i = width;
    addr_i  = addr;
    wdata_i = wdata;
    acc     = 1'b0;
    start   = -1;
    while (!acc) begin
      drive_stalls();
      @(negedge clk);
      if (start < 0) start = cyc;
      watch_outputs();
      acc = !bp_o;
      if (acc) note_accept(op, width, addr, wdata, start);
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drain_pending();
    op_i         = lsu_pkg::NO_LSU;
    stall_addr_i = 1'b0;
    stall_data_i = 1'b0;
    while (exp_data_q.size() != 0 || st_faults_pending != 0) begin
      @(negedge clk);
      watch_outputs();
      @(posedge clk);
      #1;
    end
  endtask

  task automatic store_then_load(input lsu_pkg::lsu_width_e width, input int idx,
                                 input logic [1:0] lo, input logic [31:0] data);
    logic [31:0] base;
    base = 32'(idx) << 2;
    run_op(lsu_pkg::LSU_STORE, lsu_pkg::LSU_W, base, data);
    run_op(lsu_pkg::LSU_LOAD, width, base | 32'(lo), 32'h0);
  endtask

  initial begin
    logic [31:0]         r;
    logic [31:0]         wd;
    lsu_pkg::lsu_op_e    op;
    lsu_pkg::lsu_width_e w;
    logic [1:0]          lo;
    reset_i           = 1'b1;
    op_i              = lsu_pkg::NO_LSU;
    width_i           = lsu_pkg::LSU_W;
    addr_i            = '0;
    wdata_i           = '0;
    stall_addr_i      = 1'b0;
    stall_data_i      = 1'b0;
    lfsr_state        = 32'd94450;
    stalls_on         = 1'b0;
    st_faults_pending = 0;
    test_name         = "reset";
    repeat (2) @(posedge clk);
    #1;
    reset_i = 1'b0;
    @(negedge clk);
    assert (!bp_o && !wb_valid_o && !trap_ld_o && !trap_st_o)
      else abort_run("bp_o, wb_valid_o or a trap was high after reset");
    @(posedge clk);
    #1;

    test_name = "fill";
    for (int i = 0; i < N_FILL; i++) begin
      run_op(lsu_pkg::LSU_STORE, lsu_pkg::LSU_W, 32'(i) << 2, {16'(i) ^ 16'hA5C3, ~16'(i)});
    end
    drain_pending();

    // No stalls, so every load also checks the one cycle latency
    test_name = "widths";
    store_then_load(lsu_pkg::LSU_B, 40, 2'd3, 32'h8012_3456);
    store_then_load(lsu_pkg::LSU_H, 41, 2'd2, 32'h9ABC_1234);
    store_then_load(lsu_pkg::LSU_W, 42, 2'd0, 32'hDEAD_BEEF);
    store_then_load(lsu_pkg::LSU_BU, 43, 2'd1, 32'h1234_F1AB);
    store_then_load(lsu_pkg::LSU_HU, 44, 2'd2, 32'hFEDC_7001);
    drain_pending();

    test_name = "partial stores";
    run_op(lsu_pkg::LSU_STORE, lsu_pkg::LSU_W, 32'd240, 32'h1122_3344);
    for (int i = 0; i < 4; i++) begin
      run_op(lsu_pkg::LSU_STORE, lsu_pkg::LSU_B, 32'd240 + 32'(i), 32'hC0FF_EE80 + 32'(i));
      run_op(lsu_pkg::LSU_LOAD, lsu_pkg::LSU_W, 32'd240, 32'h0);
    end
    for (int i = 0; i < 2; i++) begin
      run_op(lsu_pkg::LSU_STORE, lsu_pkg::LSU_H, 32'd240 + 32'(2 * i), 32'h5A5A_8000 + 32'(i));
      run_op(lsu_pkg::LSU_LOAD, lsu_pkg::LSU_W, 32'd240, 32'h0);
    end
    drain_pending();

    test_name = "faults";
    run_op(lsu_pkg::LSU_LOAD, lsu_pkg::LSU_W, 32'(`LSU_RAM_WORDS + 7) << 2, 32'h0);
    run_op(lsu_pkg::LSU_STORE, lsu_pkg::LSU_W, 32'(`LSU_RAM_WORDS + 7) << 2, 32'hBAD0_BAD0);
    drain_pending();
    // Word 7 is where a wrapped fault store would have landed
    run_op(lsu_pkg::LSU_LOAD, lsu_pkg::LSU_W, 32'd28, 32'h0);
    drain_pending();

    test_name = "random";
    stalls_on = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      take_bits(3, r);
      if (r[2:0] == 3'd0) op = lsu_pkg::NO_LSU;
      else if (r[0]) op = lsu_pkg::LSU_LOAD;
      else op = lsu_pkg::LSU_STORE;
      take_bits(3, r);
      w = pick_width(r[2:0]);
      take_bits(7, r);
      case (w)
        lsu_pkg::LSU_B, lsu_pkg::LSU_BU: lo = r[1:0];
        lsu_pkg::LSU_H, lsu_pkg::LSU_HU: lo = {r[1], 1'b0};
        default:                         lo = 2'b00;
      endcase
      take_bits(32, wd);
      run_op(op, w, {25'h0, r[6:2], lo}, wd);
    end
    stalls_on = 1'b0;
    drain_pending();

    $display("Result: PASSED");
    $finish;
  end

endmodule
